// ==== compile.f ====
src/exe_types_pkg.sv
src/exe_ctrl_pkg.sv
src/exe_stage_reg.sv
src/exe_alu.sv
src/exe_branch_unit.sv
src/exe_commit_sel.sv
src/exe_stage_top.sv
tb/tb_exe_stage.sv

// ==== Makefile ====
# Verilator build for the execute stage testbench
TOP       ?= tb_exe_stage
SEED_LOG  ?= sim.log
TIMEOUT   ?= 120
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard src/*.sv) $(wildcard tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): compile.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f compile.f --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	timeout $(TIMEOUT) ./$(OBJ_DIR)/V$(TOP) > $(SEED_LOG) 2>&1; status=$$?; \
	cat $(SEED_LOG); \
	if grep -q '>>> FAIL' $(SEED_LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(SEED_LOG)

// ==== tb/tb_exe_stage.sv ====
`timescale 1ns/10ps

module tb_exe_stage import exe_types_pkg::*, exe_ctrl_pkg::*; ();

    localparam int RST_CYCLES     = 16;
    localparam int N_ALU          = 300;
    localparam int N_BRANCH       = 200;
    localparam int N_STALL        = 40;
    localparam int MAX_STALL      = 8;
    localparam int N_GATE         = 200;
    localparam int STIM_CYCLES    = 2 + N_ALU + N_BRANCH + N_STALL * (1 + MAX_STALL) + N_GATE;
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + RST_CYCLES;

    logic      clk;
    logic      rst;
    logic      enable;
    logic      valid_in;
    trap_t     trap_in;
    reg_idx_t  rd_in;
    data_t     rs1_val_in;
    data_t     rs2_val_in;
    data_t     imm_in;
    addr_t     pc_in;
    alu_op_e   alu_op_in;
    src_sel_e  src_sel_in;
    br_op_e    br_op_in;
    mem_ctrl_t mem_ctrl_in;
    wb_ctrl_e  wb_ctrl_in;
    logic      valid_out;
    reg_idx_t  rd_out;
    data_t     result;
    logic      wb_en;
    logic      redirect;
    addr_t     redirect_pc;
    trap_t     trap_out;
    mem_ctrl_t mem_ctrl_out;

    // model copy of the instruction held in the stage
    logic      m_valid;
    trap_t     m_trap;
    reg_idx_t  m_rd;
    data_t     m_rs1;
    data_t     m_rs2;
    data_t     m_imm;
    addr_t     m_pc;
    alu_op_e   m_alu_op;
    src_sel_e  m_src;
    br_op_e    m_br;
    mem_ctrl_t m_mem;
    wb_ctrl_e  m_wb;

    // outputs seen just before a stall
    logic [63:0] snap [8];

    int          pass_cnt  = 0;
    int          err_cnt   = 0;
    int          cycle_cnt = 0;

    exe_stage_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic check(input logic [63:0] exp, input logic [63:0] act, input string what);
        if (exp !== act) begin
            err_cnt++;
            $display("[FAIL] %0d ns: %s expected %h, got %h", $time, what, exp, act);
        end else begin
            pass_cnt++;
        end
    endtask

    function automatic data_t sext32(input logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    function automatic data_t model_alu(input alu_op_e op, input src_sel_e sel, input data_t rs1,
                                        input data_t rs2, input data_t imm, input addr_t pc);
        data_t       a;
        data_t       b;
        data_t       r;
        logic [31:0] w;
        case (sel)
            SRC_RS_RS, SRC_RS_IMM:   a = rs1;
            SRC_PC_IMM, SRC_PC_FOUR: a = pc;
            default:                 a = '0;
        endcase
        case (sel)
            SRC_RS_RS:                            b = rs2;
            SRC_PC_FOUR:                          b = 64'd4;
            SRC_RS_IMM, SRC_PC_IMM, SRC_ZERO_IMM: b = imm;
            default:                              b = '0;
        endcase
        w = $signed(a[31:0]) >>> b[4:0];
        case (op)
            ALU_ADD:    r = a + b;
            ALU_SUB:    r = a - b;
            ALU_SLL:    r = a << b[5:0];
            ALU_SLT:    r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            ALU_SLTU:   r = (a < b) ? 64'd1 : 64'd0;
            ALU_XOR:    r = a ^ b;
            ALU_SRL:    r = a >> b[5:0];
            ALU_SRA:    r = $signed(a) >>> b[5:0];
            ALU_OR:     r = a | b;
            ALU_AND:    r = a & b;
            ALU_ADDW:   r = sext32(a[31:0] + b[31:0]);
            ALU_SUBW:   r = sext32(a[31:0] - b[31:0]);
            ALU_SLLW:   r = sext32(a[31:0] << b[4:0]);
            ALU_SRLW:   r = sext32(a[31:0] >> b[4:0]);
            ALU_SRAW:   r = sext32(w);
            ALU_PASS_B: r = b;
            default:    r = '0;
        endcase
        return r;
    endfunction

    function automatic logic model_taken(input br_op_e op, input data_t rs1, input data_t rs2);
        case (op)
            BR_BEQ:          return rs1 == rs2;
            BR_BNE:          return rs1 != rs2;
            BR_BLT:          return $signed(rs1) < $signed(rs2);
            BR_BGE:          return $signed(rs1) >= $signed(rs2);
            BR_BLTU:         return rs1 < rs2;
            BR_BGEU:         return rs1 >= rs2;
            BR_JAL, BR_JALR: return 1'b1;
            default:         return 1'b0;
        endcase
    endfunction

    function automatic addr_t model_target(input br_op_e op, input data_t rs1, input data_t imm,
                                           input addr_t pc);
        addr_t sum;
        if (op == BR_JALR) begin
            sum = rs1 + imm;
            return {sum[63:1], 1'b0};
        end
        return pc + imm;
    endfunction

    task automatic compare_outputs();
        logic  taken;
        addr_t target;
        trap_t trap_exp;
        logic  redir_exp;
        logic  wb_exp;
        taken  = model_taken(m_br, m_rs1, m_rs2);
        target = model_target(m_br, m_rs1, m_imm, m_pc);
        if (m_trap != TRAP_NONE) begin
            trap_exp = m_trap;
        end else if (taken && target[1]) begin
            trap_exp = TRAP_MISALIGN;
        end else begin
            trap_exp = TRAP_NONE;
        end
        redir_exp = m_valid && taken && (trap_exp == TRAP_NONE);
        wb_exp    = m_valid && (m_wb == WB_ALU) && (trap_exp == TRAP_NONE) && (m_rd != 5'd0);
        check(64'(m_valid), 64'(valid_out), "valid_out");
        check(64'(m_rd), 64'(rd_out), "rd_out");
        check(64'(m_mem), 64'(mem_ctrl_out), "mem_ctrl_out");
        check(model_alu(m_alu_op, m_src, m_rs1, m_rs2, m_imm, m_pc), result, "result");
        check(64'(trap_exp), 64'(trap_out), "trap_out");
        check(64'(redir_exp), 64'(redirect), "redirect");
        check(64'(wb_exp), 64'(wb_en), "wb_en");
        if (redir_exp) begin
            check(target, redirect_pc, "redirect_pc");
        end
    endtask

    task automatic drive_random();
        valid_in    = 1'b1;
        trap_in     = TRAP_NONE;
        rd_in       = reg_idx_t'($urandom);
        rs1_val_in  = {$urandom, $urandom};
        rs2_val_in  = {$urandom, $urandom};
        imm_in      = {$urandom, $urandom};
        pc_in       = data_t'({$urandom, $urandom}) & ~data_t'(3);
        alu_op_in   = alu_op_e'(5'($urandom_range(0, 16)));
        src_sel_in  = src_sel_e'(3'($urandom_range(0, 5)));
        br_op_in    = br_op_e'(4'($urandom_range(0, 8)));
        mem_ctrl_in = mem_ctrl_t'($urandom);
        wb_ctrl_in  = wb_ctrl_e'(3'($urandom_range(0, 2)));
    endtask

    // entered 2 ns after an edge with inputs driven, leaves at the same point a cycle later
    task automatic step();
        @(posedge clk);
        if (enable) begin
            m_valid  = valid_in;
            m_trap   = trap_in;
            m_rd     = rd_in;
            m_rs1    = rs1_val_in;
            m_rs2    = rs2_val_in;
            m_imm    = imm_in;
            m_pc     = pc_in;
            m_alu_op = alu_op_in;
            m_src    = src_sel_in;
            m_br     = br_op_in;
            m_mem    = mem_ctrl_in;
            m_wb     = wb_ctrl_in;
        end
        #1;
        compare_outputs();
        #1;
    endtask

    task automatic hold_snapshot();
        snap[0] = 64'(valid_out);
        snap[1] = 64'(rd_out);
        snap[2] = result;
        snap[3] = 64'(wb_en);
        snap[4] = 64'(redirect);
        snap[5] = redirect_pc;
        snap[6] = 64'(trap_out);
        snap[7] = 64'(mem_ctrl_out);
    endtask

    task automatic compare_to_snapshot();
        check(snap[0], 64'(valid_out), "stall valid_out");
        check(snap[1], 64'(rd_out), "stall rd_out");
        check(snap[2], result, "stall result");
        check(snap[3], 64'(wb_en), "stall wb_en");
        check(snap[4], 64'(redirect), "stall redirect");
        check(snap[5], redirect_pc, "stall redirect_pc");
        check(snap[6], 64'(trap_out), "stall trap_out");
        check(snap[7], 64'(mem_ctrl_out), "stall mem_ctrl_out");
    endtask

    task automatic report_test(input string name, input int checks_before, input int errs_before);
        $display("test %-8s done: %0d checks, %0d errors", name,
                 pass_cnt + err_cnt - checks_before, err_cnt - errs_before);
    endtask

    initial begin
        int c0;
        int e0;
        int n;
        void'($urandom(32'h35f4));
        rst         = 1'b1;
        enable      = 1'b0;
        valid_in    = 1'b0;
        trap_in     = TRAP_NONE;
        rd_in       = '0;
        rs1_val_in  = '0;
        rs2_val_in  = '0;
        imm_in      = '0;
        pc_in       = '0;
        alu_op_in   = ALU_NOP;
        src_sel_in  = SRC_NOP;
        br_op_in    = BR_NONE;
        mem_ctrl_in = '0;
        wb_ctrl_in  = WB_NONE;
        // bubble held after reset
        m_valid  = 1'b0;
        m_trap   = TRAP_NONE;
        m_rd     = '0;
        m_rs1    = '0;
        m_rs2    = '0;
        m_imm    = '0;
        m_pc     = RESET_PC;
        m_alu_op = ALU_NOP;
        m_src    = SRC_NOP;
        m_br     = BR_NONE;
        m_mem    = '0;
        m_wb     = WB_NONE;
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;

        c0 = pass_cnt + err_cnt;
        e0 = err_cnt;
        step();
        check(64'd0, 64'(valid_out), "reset valid_out");
        check(64'd0, 64'(wb_en), "reset wb_en");
        check(64'd0, 64'(redirect), "reset redirect");
        check(64'(TRAP_NONE), 64'(trap_out), "reset trap_out");
        report_test("reset", c0, e0);

        c0 = pass_cnt + err_cnt;
        e0 = err_cnt;
        for (int i = 0; i < N_ALU; i++) begin
            drive_random();
            // walk through every op, sources stay random
            alu_op_in = alu_op_e'(5'(i % 17));
            br_op_in  = BR_NONE;
            enable    = 1'b1;
            step();
        end
        report_test("alu", c0, e0);

        c0 = pass_cnt + err_cnt;
        e0 = err_cnt;
        for (int i = 0; i < N_BRANCH; i++) begin
            drive_random();
            if ($urandom_range(0, 3) == 0) begin
                rs2_val_in = rs1_val_in;
            end
            alu_op_in = ALU_PASS_B;
            src_sel_in = SRC_PC_FOUR;
            enable    = 1'b1;
            step();
        end
        report_test("branch", c0, e0);

        c0 = pass_cnt + err_cnt;
        e0 = err_cnt;
        for (int i = 0; i < N_STALL; i++) begin
            drive_random();
            enable = 1'b1;
            step();
            hold_snapshot();
            n = $urandom_range(1, MAX_STALL);
            repeat (n) begin
                drive_random();
                enable = 1'b0;
                step();
                compare_to_snapshot();
            end
        end
        report_test("stall", c0, e0);

        c0 = pass_cnt + err_cnt;
        e0 = err_cnt;
        for (int i = 0; i < N_GATE; i++) begin
            drive_random();
            valid_in = ($urandom_range(0, 3) != 0);
            if ($urandom_range(0, 1) == 1) begin
                trap_in = trap_t'($urandom_range(1, 3));
            end
            if ($urandom_range(0, 3) == 0) begin
                rd_in = '0;
            end
            enable = 1'b1;
            step();
        end
        report_test("gating", c0, e0);

        $display("summary: %0d checks passed, %0d checks failed", pass_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== src/exe_stage_top.sv ====
`timescale 1ns/10ps

module exe_stage_top import exe_types_pkg::*, exe_ctrl_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      enable,
    input  logic      valid_in,
    input  trap_t     trap_in,
    input  reg_idx_t  rd_in,
    input  data_t     rs1_val_in,
    input  data_t     rs2_val_in,
    input  data_t     imm_in,
    input  addr_t     pc_in,
    input  alu_op_e   alu_op_in,
    input  src_sel_e  src_sel_in,
    input  br_op_e    br_op_in,
    input  mem_ctrl_t mem_ctrl_in,
    input  wb_ctrl_e  wb_ctrl_in,
    output logic      valid_out,
    output reg_idx_t  rd_out,
    output data_t     result,
    output logic      wb_en,
    output logic      redirect,
    output addr_t     redirect_pc,
    output trap_t     trap_out,
    output mem_ctrl_t mem_ctrl_out
);

    trap_t    trap_q;
    data_t    rs1_val_q;
    data_t    rs2_val_q;
    data_t    imm_q;
    addr_t    pc_q;
    alu_op_e  alu_op_q;
    src_sel_e src_sel_q;
    br_op_e   br_op_q;
    wb_ctrl_e wb_ctrl_q;
    data_t    alu_result;
    logic     br_taken;
    addr_t    br_target;

    exe_stage_reg u_reg (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .valid_in    (valid_in),
        .trap_in     (trap_in),
        .rd_in       (rd_in),
        .rs1_val_in  (rs1_val_in),
        .rs2_val_in  (rs2_val_in),
        .imm_in      (imm_in),
        .pc_in       (pc_in),
        .alu_op_in   (alu_op_in),
        .src_sel_in  (src_sel_in),
        .br_op_in    (br_op_in),
        .mem_ctrl_in (mem_ctrl_in),
        .wb_ctrl_in  (wb_ctrl_in),
        .valid_q     (valid_out),
        .trap_q      (trap_q),
        .rd_q        (rd_out),
        .rs1_val_q   (rs1_val_q),
        .rs2_val_q   (rs2_val_q),
        .imm_q       (imm_q),
        .pc_q        (pc_q),
        .alu_op_q    (alu_op_q),
        .src_sel_q   (src_sel_q),
        .br_op_q     (br_op_q),
        .mem_ctrl_q  (mem_ctrl_out),
        .wb_ctrl_q   (wb_ctrl_q)
    );

    exe_alu u_alu (
        .alu_op     (alu_op_q),
        .src_sel    (src_sel_q),
        .rs1_val    (rs1_val_q),
        .rs2_val    (rs2_val_q),
        .imm        (imm_q),
        .pc         (pc_q),
        .alu_result (alu_result)
    );

    exe_branch_unit u_branch (
        .br_op     (br_op_q),
        .rs1_val   (rs1_val_q),
        .rs2_val   (rs2_val_q),
        .imm       (imm_q),
        .pc        (pc_q),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

    exe_commit_sel u_commit (
        .valid       (valid_out),
        .trap_in     (trap_q),
        .rd          (rd_out),
        .wb_ctrl     (wb_ctrl_q),
        .alu_result  (alu_result),
        .br_taken    (br_taken),
        .br_target   (br_target),
        .result      (result),
        .wb_en       (wb_en),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .trap_out    (trap_out)
    );

endmodule

// ==== src/exe_commit_sel.sv ====
`timescale 1ns/10ps

module exe_commit_sel import exe_types_pkg::*, exe_ctrl_pkg::*; (
    input  logic     valid,
    input  trap_t    trap_in,
    input  reg_idx_t rd,
    input  wb_ctrl_e wb_ctrl,
    input  data_t    alu_result,
    input  logic     br_taken,
    input  addr_t    br_target,
    output data_t    result,
    output logic     wb_en,
    output logic     redirect,
    output addr_t    redirect_pc,
    output trap_t    trap_out
);

    logic misalign;

    // no compressed support, so targets must be 4-byte aligned
    assign misalign = br_taken && br_target[1];

    // trap from decode wins over our own
    always_comb begin
        if (trap_in != TRAP_NONE) begin
            trap_out = trap_in;
        end else if (misalign) begin
            trap_out = TRAP_MISALIGN;
        end else begin
            trap_out = TRAP_NONE;
        end
    end

    assign redirect = valid && br_taken && (trap_out == TRAP_NONE);

    // x0 writes dropped here rather than in the register file
    assign wb_en = valid && (wb_ctrl == WB_ALU) && (trap_out == TRAP_NONE) && (rd != RD_NONE);

    assign result      = alu_result;
    assign redirect_pc = br_target;

endmodule

// ==== src/exe_branch_unit.sv ====
`timescale 1ns/10ps

module exe_branch_unit import exe_types_pkg::*, exe_ctrl_pkg::*; (
    input  br_op_e br_op,
    input  data_t  rs1_val,
    input  data_t  rs2_val,
    input  data_t  imm,
    input  addr_t  pc,
    output logic   br_taken,
    output addr_t  br_target
);

    logic eq;
    logic lt;
    logic ltu;

    assign eq  = (rs1_val == rs2_val);
    assign lt  = ($signed(rs1_val) < $signed(rs2_val));
    assign ltu = (rs1_val < rs2_val);

    always_comb begin
        case (br_op)
            BR_BEQ:  br_taken = eq;
            BR_BNE:  br_taken = !eq;
            BR_BLT:  br_taken = lt;
            BR_BGE:  br_taken = !lt;
            BR_BLTU: br_taken = ltu;
            BR_BGEU: br_taken = !ltu;
            BR_JAL,
            BR_JALR: br_taken = 1'b1;
            default: br_taken = 1'b0;
        endcase
    end

    always_comb begin
        // jalr is register relative with the lsb dropped
        if (br_op == BR_JALR) begin
            br_target = (rs1_val + imm) & ~addr_t'(1);
        end else begin
            br_target = pc + imm;
        end
    end

endmodule

// ==== src/exe_alu.sv ====
`timescale 1ns/10ps

module exe_alu import exe_types_pkg::*, exe_ctrl_pkg::*; (
    input  alu_op_e  alu_op,
    input  src_sel_e src_sel,
    input  data_t    rs1_val,
    input  data_t    rs2_val,
    input  data_t    imm,
    input  addr_t    pc,
    output data_t    alu_result
);

    data_t                   op_a;
    data_t                   op_b;
    word_t                   a_w;
    word_t                   b_w;
    logic [SHAMT_W-1:0]      shamt;
    logic [SHAMT_WORD_W-1:0] shamt_w;

    function automatic data_t sext_word(input word_t w);
        return {{(XLEN-WORD_W){w[WORD_W-1]}}, w};
    endfunction

    always_comb begin
        case (src_sel)
            SRC_RS_RS: begin
                op_a = rs1_val;
                op_b = rs2_val;
            end
            SRC_RS_IMM: begin
                op_a = rs1_val;
                op_b = imm;
            end
            SRC_PC_IMM: begin
                op_a = pc;
                op_b = imm;
            end
            SRC_PC_FOUR: begin
                op_a = pc;
                op_b = LINK_OFFSET;
            end
            SRC_ZERO_IMM: begin
                op_a = DATA_ZERO;
                op_b = imm;
            end
            default: begin
                op_a = DATA_ZERO;
                op_b = DATA_ZERO;
            end
        endcase
    end

    assign a_w     = op_a[WORD_W-1:0];
    assign b_w     = op_b[WORD_W-1:0];
    assign shamt   = op_b[SHAMT_W-1:0];
    assign shamt_w = op_b[SHAMT_WORD_W-1:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:    alu_result = op_a + op_b;
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_SLL:    alu_result = op_a << shamt;
            ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_result = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SRL:    alu_result = op_a >> shamt;
            ALU_SRA:    alu_result = data_t'($signed(op_a) >>> shamt);
            ALU_OR:     alu_result = op_a | op_b;
            ALU_AND:    alu_result = op_a & op_b;
            // word ops work on the low half, then sign-extend
            ALU_ADDW:   alu_result = sext_word(a_w + b_w);
            ALU_SUBW:   alu_result = sext_word(a_w - b_w);
            ALU_SLLW:   alu_result = sext_word(a_w << shamt_w);
            ALU_SRLW:   alu_result = sext_word(a_w >> shamt_w);
            ALU_SRAW:   alu_result = sext_word(word_t'($signed(a_w) >>> shamt_w));
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = DATA_ZERO;
        endcase
    end

endmodule

// ==== src/exe_stage_reg.sv ====
`timescale 1ns/10ps

module exe_stage_reg import exe_types_pkg::*, exe_ctrl_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      enable,
    input  logic      valid_in,
    input  trap_t     trap_in,
    input  reg_idx_t  rd_in,
    input  data_t     rs1_val_in,
    input  data_t     rs2_val_in,
    input  data_t     imm_in,
    input  addr_t     pc_in,
    input  alu_op_e   alu_op_in,
    input  src_sel_e  src_sel_in,
    input  br_op_e    br_op_in,
    input  mem_ctrl_t mem_ctrl_in,
    input  wb_ctrl_e  wb_ctrl_in,
    output logic      valid_q,
    output trap_t     trap_q,
    output reg_idx_t  rd_q,
    output data_t     rs1_val_q,
    output data_t     rs2_val_q,
    output data_t     imm_q,
    output addr_t     pc_q,
    output alu_op_e   alu_op_q,
    output src_sel_e  src_sel_q,
    output br_op_e    br_op_q,
    output mem_ctrl_t mem_ctrl_q,
    output wb_ctrl_e  wb_ctrl_q
);

    // reset loads a bubble, low enable holds the instruction
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q    <= 1'b0;
            trap_q     <= TRAP_NONE;
            rd_q       <= RD_NONE;
            rs1_val_q  <= DATA_ZERO;
            rs2_val_q  <= DATA_ZERO;
            imm_q      <= DATA_ZERO;
            pc_q       <= RESET_PC;
            alu_op_q   <= ALU_NOP;
            src_sel_q  <= SRC_NOP;
            br_op_q    <= BR_NONE;
            mem_ctrl_q <= MEM_CTRL_NOP;
            wb_ctrl_q  <= WB_NONE;
        end else if (enable) begin
            valid_q    <= valid_in;
            trap_q     <= trap_in;
            rd_q       <= rd_in;
            rs1_val_q  <= rs1_val_in;
            rs2_val_q  <= rs2_val_in;
            imm_q      <= imm_in;
            pc_q       <= pc_in;
            alu_op_q   <= alu_op_in;
            src_sel_q  <= src_sel_in;
            br_op_q    <= br_op_in;
            mem_ctrl_q <= mem_ctrl_in;
            wb_ctrl_q  <= wb_ctrl_in;
        end
    end

    // upstream must never present an unknown valid
    a_valid_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(valid_q))
        else $error("exe_stage_reg: valid_q unknown");

endmodule

// ==== src/exe_ctrl_pkg.sv ====
package exe_ctrl_pkg;

    import exe_types_pkg::*;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_ADDW, ALU_SUBW, ALU_SLLW, ALU_SRLW, ALU_SRAW,
        ALU_PASS_B, ALU_NOP
    } alu_op_e;

    // operand pair feeding the alu
    typedef enum logic [2:0] {
        SRC_RS_RS, SRC_RS_IMM, SRC_PC_IMM, SRC_PC_FOUR, SRC_ZERO_IMM, SRC_NOP
    } src_sel_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
    } br_op_e;

    // WB_MEM belongs to the load path, no write from this stage
    typedef enum logic [2:0] {
        WB_NONE, WB_ALU, WB_MEM
    } wb_ctrl_e;

    typedef enum logic [TRAP_W-1:0] {
        TRAP_NONE, TRAP_ILLEGAL, TRAP_ECALL, TRAP_MISALIGN
    } trap_e;

    localparam addr_t RESET_PC = addr_t'(32'h3000_0000);

    // bubble contents
    localparam mem_ctrl_t MEM_CTRL_NOP = '0;
    localparam reg_idx_t  RD_NONE      = '0;
    localparam data_t     DATA_ZERO    = '0;

    // return address step for jal/jalr
    localparam data_t LINK_OFFSET = data_t'(4);

endpackage

// ==== src/exe_types_pkg.sv ====
package exe_types_pkg;

    localparam int XLEN       = 64;
    localparam int WORD_W     = 32;
    localparam int REG_IDX_W  = 5;
    localparam int TRAP_W     = 4;
    localparam int MEM_CTRL_W = 4;

    // shift amount widths, full and word ops
    localparam int SHAMT_W      = 6;
    localparam int SHAMT_WORD_W = 5;

    typedef logic [XLEN-1:0]       data_t;
    typedef logic [XLEN-1:0]       addr_t;
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_IDX_W-1:0]  reg_idx_t;
    typedef logic [TRAP_W-1:0]     trap_t;

    // opaque to this stage, decoded by the memory stage
    typedef logic [MEM_CTRL_W-1:0] mem_ctrl_t;

endpackage
